// ==== verilog/gpuPkg.sv ====
package gpuPkg;

	// ------------------------------------------------------------
	// Basic data types.
	// ------------------------------------------------------------
	typedef logic [31:0]        cmdWord_t;   // One GP0 or GP1 word.
	typedef logic signed [11:0] coord_t;     // 11-bit field plus 11-bit offset.
	typedef logic [8:0]         colorComp_t; // 0..100h after widening.

	typedef struct packed {
		coord_t     x;
		coord_t     y;
		colorComp_t r;
		colorComp_t g;
		colorComp_t b;
	} vertex_t;

	typedef enum logic [1:0] {IDLE, COMMAND, COLOR, VERTEX} parseState_t;

	// Low nibble of an Ex attribute command.
	typedef enum logic [3:0] {
		TEXPAGE = 4'd1,
		AREA_TL = 4'd3,
		AREA_BR = 4'd4,
		OFFSET  = 4'd5,
		MASK    = 4'd6
	} attribSel_t;

	// GP1 opcode, bits 29:24 of the control word.
	typedef enum logic [5:0] {
		RESET       = 6'h00,
		RESET_CMD   = 6'h01,
		DISP_ENABLE = 6'h03,
		DMA_DIR     = 6'h04,
		DISP_MODE   = 6'h08
	} gp1Op_t;

	// Primary opcodes. Bits 3:2 must be clear for untextured triangles.
	localparam logic [7:0] POLY_MASK    = 8'hFC;
	localparam logic [7:0] POLY_FLAT    = 8'h20;
	localparam logic [7:0] POLY_GOURAUD = 8'h30;
	localparam logic [7:0] ATTRIB_BASE  = 8'hE0;

	// ------------------------------------------------------------
	// Status word layout.
	// ------------------------------------------------------------
	localparam int STAT_DRAW_LSB     = 0;  // Draw mode, 11 bits.
	localparam int STAT_MASK_LSB     = 11; // Force mask, check mask.
	localparam int STAT_REVERSE      = 14;
	localparam int STAT_DISP_LSB     = 16; // Display mode, 7 bits.
	localparam int STAT_DISP_OFF     = 23;
	localparam int STAT_CMD_READY    = 26;
	localparam int STAT_DMA_READY    = 28;
	localparam int STAT_DMA_DIR_LSB  = 29;

	localparam logic       DISP_OFF_RESET = 1'b1;
	localparam logic [9:0] AREA_BR_RESET  = 10'd1023;

endpackage

// ==== verilog/gpuIfs.sv ====
`timescale 1ns/1ps

// Strobes from the parser to the vertex slots, one FIFO word each.
interface vertexLoadIf import gpuPkg::*; ();
	cmdWord_t   word;
	logic       loadColor;
	logic       loadAllColor; // Flat shading, color goes to every slot.
	logic       loadVertex;
	logic [1:0] slot;         // 0..2.
	logic       issue;        // Last vertex of the triangle.

	modport decoder (output word, loadColor, loadAllColor, loadVertex, slot, issue);
	modport loader  (input  word, loadColor, loadAllColor, loadVertex, slot, issue);
endinterface

interface triangleIf import gpuPkg::*; ();
	vertex_t v0, v1, v2; // Arrival order.
	logic    issue;

	modport loader (output v0, v1, v2, issue);
	modport sorter (input  v0, v1, v2, issue);
endinterface

// ==== verilog/gpuCmdFifo.sv ====
`timescale 1ns/1ps

module gpuCmdFifo import gpuPkg::*; #(
	parameter int FIFO_DEPTH_LOG2 = 4
) (
	input  logic     clk,
	input  logic     i_nrst,
	input  logic     flush,
	input  logic     write,
	input  cmdWord_t writeData,
	input  logic     read,
	output cmdWord_t readData,
	output logic     full,
	output logic     empty
);

	localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;

	cmdWord_t mem [DEPTH];
	logic [FIFO_DEPTH_LOG2:0] wrPtr; // Extra MSB tells full from empty.
	logic [FIFO_DEPTH_LOG2:0] rdPtr;
	logic doWrite;
	logic doRead;

	assign empty   = (wrPtr == rdPtr);
	assign full    = (wrPtr[FIFO_DEPTH_LOG2] != rdPtr[FIFO_DEPTH_LOG2]) &&
	                 (wrPtr[FIFO_DEPTH_LOG2-1:0] == rdPtr[FIFO_DEPTH_LOG2-1:0]);
	assign doWrite = write & ~full;
	assign doRead  = read & ~empty;

	always_ff @(posedge clk) begin
		if (!i_nrst || flush) begin // Flush drops everything in one cycle.
			wrPtr <= '0;
			rdPtr <= '0;
		end else begin
			if (doWrite) wrPtr <= wrPtr + 1'b1;
			if (doRead)  rdPtr <= rdPtr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (doWrite) mem[wrPtr[FIFO_DEPTH_LOG2-1:0]] <= writeData;
		if (doRead)  readData <= mem[rdPtr[FIFO_DEPTH_LOG2-1:0]]; // Head valid next cycle.
	end

endmodule

// ==== verilog/gpuCmdDecoder.sv ====
`timescale 1ns/1ps

module gpuCmdDecoder import gpuPkg::*; (
	input  logic       clk,
	input  logic       i_nrst,
	input  logic       parserReset,
	input  logic       fifoEmpty,
	input  cmdWord_t   fifoData,
	output logic       fifoRead,
	output logic       attribLoad,
	output attribSel_t attribSel,
	output logic       parserIdle,
	vertexLoadIf.decoder vtx
);

	parseState_t state;
	parseState_t nextState;
	parseState_t afterCmd;
	logic        dataValid;  // fifoData holds a word read last cycle.
	logic [1:0]  vertexCnt;
	logic        gouraud;
	logic        isAttrib;
	logic        isPoly;

	assign fifoRead   = ~fifoEmpty & ~parserReset; // One word per cycle.
	assign parserIdle = (state == IDLE);
	assign attribSel  = attribSel_t'(fifoData[27:24]);
	assign afterCmd   = fifoRead ? COMMAND : IDLE; // Next word already on its way?

	// ------------------------------------------------------------
	// Command classification.
	// ------------------------------------------------------------
	assign isAttrib = (fifoData[31:28] == ATTRIB_BASE[7:4]) &&
	                  (attribSel inside {TEXPAGE, AREA_TL, AREA_BR, OFFSET, MASK});
	assign isPoly   = ((fifoData[31:24] & POLY_MASK) == POLY_FLAT) ||
	                  ((fifoData[31:24] & POLY_MASK) == POLY_GOURAUD);

	assign vtx.word = fifoData;

	always_comb begin
		nextState        = state;
		attribLoad       = 1'b0;
		vtx.loadColor    = 1'b0;
		vtx.loadAllColor = 1'b0;
		vtx.loadVertex   = 1'b0;
		vtx.slot         = vertexCnt;
		vtx.issue        = 1'b0;
		case (state)
			IDLE: begin
				if (fifoRead) nextState = COMMAND;
			end
			COMMAND: begin
				if (dataValid) begin
					nextState = afterCmd; // Attributes and no-ops take one word.
					if (isAttrib) begin
						attribLoad = 1'b1;
					end else if (isPoly) begin
						vtx.loadColor    = 1'b1; // Command carries first color.
						vtx.loadAllColor = ~fifoData[28];
						vtx.slot         = 2'd0;
						nextState        = VERTEX;
					end
				end
			end
			COLOR: begin
				if (dataValid) begin
					vtx.loadColor = 1'b1;
					nextState     = VERTEX;
				end
			end
			VERTEX: begin
				if (dataValid) begin
					vtx.loadVertex = 1'b1;
					if (vertexCnt == 2'd2) begin
						vtx.issue = 1'b1; // Triangle complete.
						nextState = afterCmd;
					end else begin
						nextState = gouraud ? COLOR : VERTEX;
					end
				end
			end
			default: nextState = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!i_nrst || parserReset) begin
			state     <= IDLE;
			dataValid <= 1'b0; // Word in flight is dropped with the FIFO.
			vertexCnt <= 2'd0;
			gouraud   <= 1'b0;
		end else begin
			state     <= nextState;
			dataValid <= fifoRead;
			if (state == COMMAND && dataValid && isPoly) begin
				vertexCnt <= 2'd0;
				gouraud   <= fifoData[28]; // Bit 4 of the opcode.
			end else if (vtx.loadVertex && vertexCnt != 2'd2) begin
				vertexCnt <= vertexCnt + 2'd1;
			end
		end
	end

endmodule

// ==== verilog/gpuRegisters.sv ====
`timescale 1ns/1ps

module gpuRegisters import gpuPkg::*; (
	input  logic              clk,
	input  logic              i_nrst,
	input  logic              cpuAddress,
	input  logic              gpuSel,
	input  logic              cpuWrite,
	input  cmdWord_t          cpuDataIn,
	input  logic              attribLoad,
	input  attribSel_t        attribSel,
	input  cmdWord_t          fifoData,
	input  logic              fifoFull,
	input  logic              fifoEmpty,
	input  logic              parserIdle,
	output logic              ack,
	output cmdWord_t          cpuDataOut,
	output logic              fifoWrite,
	output logic              fifoFlush,
	output logic              parserReset,
	output logic signed [10:0] offsetX,
	output logic signed [10:0] offsetY
);

	logic       gp1Write;
	gp1Op_t     gp1Op;
	logic       gpuReset;
	logic [10:0] drawMode; // E1 bits 10:0.
	logic [1:0] maskSet;   // E6.
	logic [9:0] areaX0, areaY0, areaX1, areaY1;
	logic       dispOff;
	logic [7:0] dispMode;
	logic [1:0] dmaDir;
	cmdWord_t   status;

	// ------------------------------------------------------------
	// CPU port decode.
	// ------------------------------------------------------------
	assign ack         = ~fifoFull;
	assign fifoWrite   = gpuSel & cpuWrite & ~cpuAddress & ~fifoFull; // GP0.
	assign gp1Write    = gpuSel & cpuWrite & cpuAddress;
	assign gp1Op       = gp1Op_t'(cpuDataIn[29:24]);
	assign gpuReset    = gp1Write && (gp1Op == RESET);
	assign parserReset = gp1Write && (gp1Op == RESET || gp1Op == RESET_CMD);
	assign fifoFlush   = parserReset;

	always_ff @(posedge clk) begin
		if (!i_nrst || gpuReset) begin
			drawMode <= '0;
			maskSet  <= '0;
			areaX0   <= '0;
			areaY0   <= '0;
			areaX1   <= AREA_BR_RESET; // Whole VRAM.
			areaY1   <= AREA_BR_RESET;
			offsetX  <= '0;
			offsetY  <= '0;
			dispOff  <= DISP_OFF_RESET;
			dispMode <= '0;
			dmaDir   <= '0;
		end else begin
			if (attribLoad) begin
				case (attribSel)
					TEXPAGE: drawMode <= fifoData[10:0];
					AREA_TL: {areaY0, areaX0} <= fifoData[19:0];
					AREA_BR: {areaY1, areaX1} <= fifoData[19:0];
					OFFSET:  {offsetY, offsetX} <= fifoData[21:0];
					MASK:    maskSet <= fifoData[1:0];
					default: ;
				endcase
			end
			if (gp1Write && gp1Op == DISP_ENABLE) dispOff  <= cpuDataIn[0];
			if (gp1Write && gp1Op == DMA_DIR)     dmaDir   <= cpuDataIn[1:0];
			if (gp1Write && gp1Op == DISP_MODE)   dispMode <= cpuDataIn[7:0];
		end
	end

	// ------------------------------------------------------------
	// Status word.
	// ------------------------------------------------------------
	always_comb begin
		status = '0;
		status[STAT_DRAW_LSB +: 11]  = drawMode;
		status[STAT_MASK_LSB +: 2]   = maskSet;
		status[STAT_REVERSE]         = dispMode[7];
		status[STAT_DISP_LSB +: 7]   = {dispMode[5:0], dispMode[6]}; // 368 mode at bit 16.
		status[STAT_DISP_OFF]        = dispOff;
		status[STAT_CMD_READY]       = fifoEmpty & parserIdle;
		status[STAT_DMA_READY]       = ~fifoFull;
		status[STAT_DMA_DIR_LSB +: 2] = dmaDir;
	end

	assign cpuDataOut = (gpuSel && cpuAddress) ? status : '0; // GPUREAD not modelled.

endmodule

// ==== verilog/gpuVertexLoader.sv ====
`timescale 1ns/1ps

module gpuVertexLoader import gpuPkg::*; (
	input  logic               clk,
	input  logic signed [10:0] offsetX,
	input  logic signed [10:0] offsetY,
	vertexLoadIf.loader        vtx,
	triangleIf.loader          triangle
);

	logic signed [10:0] rawX;
	logic signed [10:0] rawY;
	coord_t     posX;
	coord_t     posY;
	colorComp_t compR, compG, compB;
	vertex_t    slotQ [3];
	logic       issueQ;

	// Untextured rule, bit 7 is added back so FFh maps to 100h.
	function automatic colorComp_t widen(input logic [7:0] c);
		return {1'b0, c} + colorComp_t'(c[7]);
	endfunction

	assign rawX  = vtx.word[10:0];
	assign rawY  = vtx.word[26:16];
	assign posX  = rawX + offsetX; // Signed, one bit wider.
	assign posY  = rawY + offsetY;
	assign compR = widen(vtx.word[7:0]);
	assign compG = widen(vtx.word[15:8]);
	assign compB = widen(vtx.word[23:16]);

	always_ff @(posedge clk) begin
		for (int i = 0; i < 3; i++) begin
			if (vtx.loadVertex && vtx.slot == 2'(i)) begin
				slotQ[i].x <= posX;
				slotQ[i].y <= posY;
			end
			if (vtx.loadColor && (vtx.loadAllColor || vtx.slot == 2'(i))) begin
				slotQ[i].r <= compR;
				slotQ[i].g <= compG;
				slotQ[i].b <= compB;
			end
		end
		issueQ <= vtx.issue; // Slots settle together with this.
	end

	assign triangle.v0    = slotQ[0];
	assign triangle.v1    = slotQ[1];
	assign triangle.v2    = slotQ[2];
	assign triangle.issue = issueQ;

endmodule

// ==== verilog/gpuTriangleSorter.sv ====
`timescale 1ns/1ps

module gpuTriangleSorter import gpuPkg::*; (
	input  logic       clk,
	input  logic       i_nrst,
	triangleIf.sorter  triangle,
	output logic       primValid,
	output coord_t     primX0, primX1, primX2,
	output coord_t     primY0, primY1, primY2,
	output colorComp_t primR0, primR1, primR2,
	output colorComp_t primG0, primG1, primG2,
	output colorComp_t primB0, primB1, primB2
);

	vertex_t    vIn  [3];
	vertex_t    outV [3];
	logic       le01, le02, le12; // Less or equal keeps arrival order on ties.
	logic [1:0] topIdx;
	logic [1:0] midIdx;
	logic [1:0] botIdx;

	assign vIn[0] = triangle.v0;
	assign vIn[1] = triangle.v1;
	assign vIn[2] = triangle.v2;

	assign le01 = (vIn[0].y <= vIn[1].y);
	assign le02 = (vIn[0].y <= vIn[2].y);
	assign le12 = (vIn[1].y <= vIn[2].y);

	assign topIdx = (le01 && le02) ? 2'd0 :
	                (!le01 && le12) ? 2'd1 : 2'd2;
	assign botIdx = (le02 && le12) ? 2'd2 :
	                (le01 && !le12) ? 2'd1 : 2'd0;
	assign midIdx = topIdx ^ botIdx ^ 2'd3; // Indices sum to 0^1^2.

	always_ff @(posedge clk) begin
		if (!i_nrst) primValid <= 1'b0;
		else         primValid <= triangle.issue;
	end

	// Held until the next triangle is issued.
	always_ff @(posedge clk) begin
		if (triangle.issue) begin
			outV[0] <= vIn[topIdx];
			outV[1] <= vIn[midIdx];
			outV[2] <= vIn[botIdx];
		end
	end

	assign primX0 = outV[0].x;
	assign primY0 = outV[0].y;
	assign primR0 = outV[0].r;
	assign primG0 = outV[0].g;
	assign primB0 = outV[0].b;
	assign primX1 = outV[1].x;
	assign primY1 = outV[1].y;
	assign primR1 = outV[1].r;
	assign primG1 = outV[1].g;
	assign primB1 = outV[1].b;
	assign primX2 = outV[2].x;
	assign primY2 = outV[2].y;
	assign primR2 = outV[2].r;
	assign primG2 = outV[2].g;
	assign primB2 = outV[2].b;

endmodule

// ==== verilog/gpuFrontEnd.sv ====
`timescale 1ns/1ps

module gpuFrontEnd import gpuPkg::*; #(
	parameter int FIFO_DEPTH_LOG2 = 4
) (
	input  logic       clk,
	input  logic       i_nrst,
	input  logic       cpuAddress, // 0 is GP0, 1 is GP1 or status.
	input  logic       gpuSel,
	input  logic       cpuWrite,
	input  cmdWord_t   cpuDataIn,
	output logic       ack,
	output cmdWord_t   cpuDataOut,
	output logic       primValid,
	output coord_t     primX0, primX1, primX2,
	output coord_t     primY0, primY1, primY2,
	output colorComp_t primR0, primR1, primR2,
	output colorComp_t primG0, primG1, primG2,
	output colorComp_t primB0, primB1, primB2
);

	logic fifoWrite, fifoFlush, fifoRead, fifoFull, fifoEmpty;
	logic parserReset, parserIdle, attribLoad;
	cmdWord_t   fifoData;
	attribSel_t attribSel;
	logic signed [10:0] offsetX, offsetY;

	vertexLoadIf vtxBus ();
	triangleIf   triBus ();

	// ------------------------------------------------------------
	// Command path.
	// ------------------------------------------------------------
	gpuRegisters gpuRegisters_inst (.*);

	gpuCmdFifo #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) gpuCmdFifo_inst (
		.clk(clk), .i_nrst(i_nrst), .flush(fifoFlush),
		.write(fifoWrite), .writeData(cpuDataIn),
		.read(fifoRead), .readData(fifoData),
		.full(fifoFull), .empty(fifoEmpty)
	);

	gpuCmdDecoder gpuCmdDecoder_inst (.*, .vtx(vtxBus.decoder));

	// Primitive path.
	gpuVertexLoader gpuVertexLoader_inst (
		.clk(clk), .offsetX(offsetX), .offsetY(offsetY),
		.vtx(vtxBus.loader), .triangle(triBus.loader)
	);

	gpuTriangleSorter gpuTriangleSorter_inst (.*, .triangle(triBus.sorter));

endmodule

// ==== dv/gpuFrontEnd_checker.sv ====
`timescale 1ns/1ps

module gpuFrontEnd_checker import gpuPkg::*; (
	input logic   clk,
	input logic   i_nrst,
	input logic   ack,
	input logic   primValid,
	input coord_t primY0,
	input coord_t primY1,
	input coord_t primY2
);

	// ------------------------------------------------------------
	// Output primitive.
	// ------------------------------------------------------------
	property singlePulse;
		@(posedge clk) disable iff (!i_nrst)
		primValid |=> !primValid; // One cycle per triangle.
	endproperty

	property sortedByY;
		@(posedge clk) disable iff (!i_nrst)
		primValid |-> (primY0 <= primY1) && (primY1 <= primY2);
	endproperty

	singlePulseA: assert property (singlePulse)
		else $error("primValid was high on two consecutive cycles.");
	sortedByYA: assert property (sortedByY)
		else $error("Primitive vertices are not ordered top to bottom.");

	// ------------------------------------------------------------
	// Reset behavior.
	// ------------------------------------------------------------
	property resetExit;
		@(posedge clk) $rose(i_nrst) |-> ack && !primValid; // Empty FIFO, nothing issued.
	endproperty

	resetExitA: assert property (resetExit)
		else $error("First cycle after reset has ack low or primValid high.");

endmodule

bind gpuFrontEnd gpuFrontEnd_checker protocolCheck (.*);

// ==== dv/gpuFrontEnd_tb.sv ====
`timescale 1ns/1ps

module gpuFrontEnd_tb import gpuPkg::*; ();

	logic       clk;
	logic       i_nrst;
	logic       cpuAddress;
	logic       gpuSel;
	logic       cpuWrite;
	cmdWord_t   cpuDataIn;
	logic       ack;
	cmdWord_t   cpuDataOut;
	logic       primValid;
	coord_t     primX0, primX1, primX2;
	coord_t     primY0, primY1, primY2;
	colorComp_t primR0, primR1, primR2;
	colorComp_t primG0, primG1, primG2;
	colorComp_t primB0, primB1, primB2;

	localparam int          TIMEOUT      = 200;          // Cycles per wait loop.
	localparam logic [31:0] RESET_STATUS = 32'h1480_0000; // Bits 23, 26 and 28.

	vertex_t     expQ [$]; // Sorted expected vertices, three per triangle.
	int          offX;     // Drawing offset as last written with E5.
	int          offY;
	logic [31:0] stat;
	logic [31:0] expStat;
	logic [31:0] rnd;

	gpuFrontEnd #(.FIFO_DEPTH_LOG2(4)) gpuFrontEnd_inst (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk; // 10 ns period.

	// ------------------------------------------------------------
	// Reporting.
	// ------------------------------------------------------------
	task automatic failRun(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] want,
	                          input logic [31:0] actual);
		assert (actual === want)
		else failRun($sformatf("[FAIL] %s: expected 0x%h, actual 0x%h", name, want, actual));
	endtask

	// ------------------------------------------------------------
	// CPU port. Called and returning on a falling edge.
	// ------------------------------------------------------------
	task automatic busWrite(input logic addr, input cmdWord_t word);
		int n;
		n = 0;
		while (!ack) begin // FIFO full, hold the write back.
			@(negedge clk);
			n++;
			if (n > TIMEOUT) failRun("Timeout: ack stayed low and the FIFO never drained.");
		end
		cpuAddress = addr;
		gpuSel     = 1'b1;
		cpuWrite   = 1'b1;
		cpuDataIn  = word;
		@(negedge clk); // Taken at the rising edge in between.
		gpuSel   = 1'b0;
		cpuWrite = 1'b0;
	endtask

	task automatic gp0Write(input cmdWord_t word);
		busWrite(1'b0, word);
	endtask

	task automatic gp1Write(input cmdWord_t word);
		busWrite(1'b1, word);
	endtask

	// Waits until the parser has drained everything, then samples the status.
	task automatic statusRead(output logic [31:0] value);
		int n;
		n = 0;
		cpuAddress = 1'b1;
		gpuSel     = 1'b1;
		cpuWrite   = 1'b0;
		do begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT) failRun("Timeout: status never showed ready for command.");
		end while (!cpuDataOut[26]);
		value  = cpuDataOut;
		gpuSel = 1'b0;
	endtask

	task automatic waitPrim();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT) failRun("Timeout: no primValid pulse arrived.");
		end while (!primValid);
	endtask

	// ------------------------------------------------------------
	// Triangle model.
	// ------------------------------------------------------------
	// Untextured widening, FFh becomes 100h.
	function automatic colorComp_t widenRule(input logic [7:0] c);
		return c[7] ? colorComp_t'(c) + 9'd1 : colorComp_t'(c);
	endfunction

	task automatic sendTriangle(input bit gouraud, input bit forceTie);
		vertex_t  v [3];
		vertex_t  tmp;
		cmdWord_t colorWord [3];
		cmdWord_t posWord [3];
		cmdWord_t c;
		logic [31:0] r;
		int j;
		for (int i = 0; i < 3; i++) begin
			r          = $urandom;
			posWord[i] = {5'd0, r[26:16], 5'd0, r[10:0]};
			if (forceTie && i == 2) posWord[2][26:16] = posWord[0][26:16]; // Equal Y.
			r            = $urandom;
			colorWord[i] = {8'h00, r[23:0]};
		end
		r = $urandom;
		colorWord[0][31:24] = (gouraud ? 8'h30 : 8'h20) | {6'd0, r[1:0]};
		for (int i = 0; i < 3; i++) begin
			c      = gouraud ? colorWord[i] : colorWord[0]; // Flat shares one color.
			v[i].x = coord_t'(int'($signed(posWord[i][10:0])) + offX);
			v[i].y = coord_t'(int'($signed(posWord[i][26:16])) + offY);
			v[i].r = widenRule(c[7:0]);
			v[i].g = widenRule(c[15:8]);
			v[i].b = widenRule(c[23:16]);
		end
		// Stable insertion sort, ties keep arrival order.
		for (int i = 1; i < 3; i++) begin
			j = i;
			while (j > 0 && v[j-1].y > v[j].y) begin
				tmp    = v[j];
				v[j]   = v[j-1];
				v[j-1] = tmp;
				j--;
			end
		end
		for (int i = 0; i < 3; i++) expQ.push_back(v[i]);
		gp0Write(colorWord[0]);
		gp0Write(posWord[0]);
		for (int i = 1; i < 3; i++) begin
			if (gouraud) gp0Write(colorWord[i]);
			gp0Write(posWord[i]);
		end
	endtask

	task automatic checkTriangle(input string name);
		vertex_t act [3];
		vertex_t want;
		waitPrim();
		act[0] = {primX0, primY0, primR0, primG0, primB0};
		act[1] = {primX1, primY1, primR1, primG1, primB1};
		act[2] = {primX2, primY2, primR2, primG2, primB2};
		for (int k = 0; k < 3; k++) begin
			if (expQ.size() == 0) failRun("primValid pulsed with no triangle outstanding.");
			want = expQ.pop_front();
			checkValue($sformatf("%s v%0d.x", name, k), want.x, act[k].x);
			checkValue($sformatf("%s v%0d.y", name, k), want.y, act[k].y);
			checkValue($sformatf("%s v%0d.r", name, k), want.r, act[k].r);
			checkValue($sformatf("%s v%0d.g", name, k), want.g, act[k].g);
			checkValue($sformatf("%s v%0d.b", name, k), want.b, act[k].b);
		end
	endtask

	// ------------------------------------------------------------
	// Test sequence.
	// ------------------------------------------------------------
	initial begin
		void'($urandom(57196));
		i_nrst     = 1'b0;
		cpuAddress = 1'b0;
		gpuSel     = 1'b0;
		cpuWrite   = 1'b0;
		cpuDataIn  = '0;
		offX       = 0;
		offY       = 0;
		repeat (10) @(negedge clk);
		i_nrst = 1'b1;

		statusRead(stat);
		checkValue("reset status", RESET_STATUS, stat);

		// Display mode, DMA direction, display on.
		rnd = $urandom;
		gp1Write({8'h08, 16'd0, rnd[7:0]});
		gp1Write({8'h04, 22'd0, rnd[9:8]});
		gp1Write({8'h03, 24'd0});
		expStat        = 32'h1400_0000; // Both ready bits.
		expStat[14]    = rnd[7];        // Reverse flag.
		expStat[16]    = rnd[6];
		expStat[22:17] = rnd[5:0];
		expStat[30:29] = rnd[9:8];
		statusRead(stat);
		checkValue("gp1 state", expStat, stat);
		gp1Write(32'h0000_0000); // Full reset.
		statusRead(stat);
		checkValue("gp1 reset", RESET_STATUS, stat);

		rnd = $urandom;
		gp0Write({8'hE1, 13'd0, rnd[10:0]});
		gp0Write({8'hE6, 22'd0, rnd[12:11]});
		statusRead(stat);
		checkValue("attributes", RESET_STATUS | {19'd0, rnd[12:0]}, stat);

		rnd  = $urandom;
		offX = int'($signed(rnd[10:0]));
		offY = int'($signed(rnd[21:11]));
		gp0Write({8'hE5, 2'd0, rnd[21:0]});
		sendTriangle(1'b0, 1'b1);
		checkTriangle("flat triangle");

		// Second triangle enters while the first drains.
		fork
			begin
				sendTriangle(1'b1, 1'b0);
				sendTriangle(1'b1, 1'b0);
			end
			begin
				checkTriangle("gouraud triangle 1");
				checkTriangle("gouraud triangle 2");
			end
		join

		// Half a Gouraud polygon, then a command flush.
		gp0Write(32'h3012_3456);
		gp0Write({5'd0, 11'd5, 5'd0, 11'd7});
		gp0Write(32'h0000_00FF);
		gp1Write(32'h0100_0000);
		sendTriangle(1'b0, 1'b0);
		checkTriangle("flush");

		if (expQ.size() == 0) begin
			$display("test passed");
			$finish;
		end else begin
			failRun("Expected triangles never came out of the DUT.");
		end
	end

endmodule

// ==== gpuFrontEnd.f ====
verilog/gpuPkg.sv
verilog/gpuIfs.sv
verilog/gpuCmdFifo.sv
verilog/gpuCmdDecoder.sv
verilog/gpuRegisters.sv
verilog/gpuVertexLoader.sv
verilog/gpuTriangleSorter.sv
verilog/gpuFrontEnd.sv
dv/gpuFrontEnd_checker.sv
dv/gpuFrontEnd_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = gpuFrontEnd_tb
FILELIST  = gpuFrontEnd.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
